//--- Bender.yml
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - control.sv
  - reg_file.sv
  - exec_unit.sv
  - cp0.sv
  - pc_unit.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_properties.sv
      - tb_mips_core.sv

//--- control.sv
`timescale 1ns/10ps

module control (
	input  mips_pkg::word_t     inst,
	output logic                ra_sel,     // operand a from rt
	output logic                beq,
	output logic                bne,
	output logic                j,
	output logic                jr,
	output mips_pkg::alu_op_t   aluop,
	output logic                sign_ext,
	output logic                srcb_imm,   // operand b from immediate
	output logic                lui,
	output logic                jal,        // link address to write-back
	output logic                mem_we,
	output logic                mem_to_reg, // load word to write-back
	output mips_pkg::reg_addr_t wb_dreg,
	output logic                wb_we,
	output logic                syscall,
	output logic                unknown,
	output logic                alu_signed, // trap on overflow
	output logic                eret,
	output logic                cp0_we,
	output mips_pkg::reg_addr_t cp0_reg,
	output logic                mfc
);
	import mips_pkg::*;

	logic [5:0] op;
	logic [5:0] fn;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;

	assign op = inst[31:26];
	assign rs = inst[25:21];
	assign rt = inst[20:16];
	assign rd = inst[15:11];
	assign fn = inst[5:0];

	always_comb begin
		ra_sel     = 1'b0;
		beq        = 1'b0;
		bne        = 1'b0;
		j          = 1'b0;
		jr         = 1'b0;
		aluop      = ALU_AND;
		sign_ext   = 1'b0;
		srcb_imm   = 1'b0;
		lui        = 1'b0;
		jal        = 1'b0;
		mem_we     = 1'b0;
		mem_to_reg = 1'b0;
		wb_dreg    = '0;
		wb_we      = 1'b0;
		syscall    = 1'b0;
		unknown    = 1'b0;
		alu_signed = 1'b0;
		eret       = 1'b0;
		cp0_we     = 1'b0;
		cp0_reg    = '0;
		mfc        = 1'b0;

		////////////////////////////////////////
		// register form
		if (inst == '0) begin
			unknown = 1'b0; // nop
		end else if (op == OP_RTYPE) begin
			wb_dreg = rd;
			case (fn)
				FN_ADD: begin
					aluop      = ALU_ADD;
					wb_we      = 1'b1;
					alu_signed = 1'b1;
				end
				FN_ADDU: begin
					aluop = ALU_ADD;
					wb_we = 1'b1;
				end
				FN_SUB: begin
					aluop      = ALU_SUB;
					wb_we      = 1'b1;
					alu_signed = 1'b1;
				end
				FN_SUBU: begin
					aluop = ALU_SUB;
					wb_we = 1'b1;
				end
				FN_SLT: begin
					aluop = ALU_SLT;
					wb_we = 1'b1;
				end
				FN_AND: begin
					aluop = ALU_AND;
					wb_we = 1'b1;
				end
				FN_OR: begin
					aluop = ALU_OR;
					wb_we = 1'b1;
				end
				FN_XOR: begin
					aluop = ALU_XOR;
					wb_we = 1'b1;
				end
				FN_NOR: begin
					aluop = ALU_NOR;
					wb_we = 1'b1;
				end
				FN_SRL: begin
					aluop    = ALU_SRL;
					wb_we    = 1'b1;
					ra_sel   = 1'b1; // shift rt by shamt
					srcb_imm = 1'b1;
				end
				FN_JR: begin
					jr      = 1'b1;
					wb_dreg = '0;
				end
				FN_JALR: begin
					jr      = 1'b1;
					jal     = 1'b1;
					wb_we   = 1'b1;
					wb_dreg = REG_RA;
				end
				FN_SYSCALL: begin
					syscall = 1'b1;
					wb_dreg = '0;
				end
				default: begin
					unknown = 1'b1;
					wb_dreg = '0;
				end
			endcase
		end else begin
			////////////////////////////////////////
			// immediate, jump and cop0 forms
			case (op)
				OP_LW, OP_SW, OP_ADDI, OP_SLTI: begin
					sign_ext = 1'b1;
					srcb_imm = 1'b1;
					aluop    = (op == OP_SLTI) ? ALU_SLT : ALU_ADD;
					mem_we   = (op == OP_SW);
					wb_we    = (op != OP_SW);
					wb_dreg  = (op == OP_SW) ? reg_addr_t'(0) : rt;
					mem_to_reg = (op == OP_LW);
					alu_signed = (op == OP_ADDI); // addi traps, addiu absent
				end
				OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
					srcb_imm = 1'b1; // zero extended
					lui      = (op == OP_LUI);
					wb_we    = 1'b1;
					wb_dreg  = rt;
					if (op == OP_ORI)
						aluop = ALU_OR;
					else if (op == OP_XORI)
						aluop = ALU_XOR;
				end
				OP_BEQ: beq = 1'b1;
				OP_BNE: bne = 1'b1;
				OP_J:   j   = 1'b1;
				OP_JAL: begin
					j       = 1'b1;
					jal     = 1'b1;
					wb_we   = 1'b1;
					wb_dreg = REG_RA;
				end
				OP_COP0: begin
					if (inst == INST_ERET) begin
						eret = 1'b1;
					end else if (rs == 5'b00000 && inst[10:3] == 8'b0) begin
						mfc     = 1'b1; // mfc0 rt, rd
						cp0_reg = rd;
						wb_we   = 1'b1;
						wb_dreg = rt;
					end else if (rs == 5'b00100 && inst[10:3] == 8'b0) begin
						cp0_we  = 1'b1; // mtc0 rt, rd
						cp0_reg = rd;
					end else begin
						unknown = 1'b1;
					end
				end
				default: unknown = 1'b1;
			endcase
		end
	end

endmodule

//--- cp0.sv
`timescale 1ns/10ps

module cp0 (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::word_t     pc,
	input  logic                syscall,
	input  logic                unknown,
	input  logic                overflow,
	input  logic                eret,
	input  logic                cp0_we,
	input  mips_pkg::reg_addr_t cp0_reg,
	input  mips_pkg::word_t     wdata,
	output mips_pkg::word_t     rdata,
	output mips_pkg::word_t     epc,
	output logic                exc_taken,
	output logic [4:0]          exc_code
);
	import mips_pkg::*;

	word_t status;
	word_t cause;

	assign exc_taken = syscall | unknown | overflow;

	// syscall wins over unknown, unknown over overflow
	always_comb begin
		if (syscall)
			exc_code = EXC_SYS;
		else if (unknown)
			exc_code = EXC_RI;
		else if (overflow)
			exc_code = EXC_OV;
		else
			exc_code = '0;
	end

	always_comb begin
		case (cp0_reg)
			CP0_STATUS: rdata = status;
			CP0_CAUSE:  rdata = cause;
			CP0_EPC:    rdata = epc;
			default:    rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			status <= '0;
			cause  <= '0;
			epc    <= '0;
		end else if (exc_taken) begin
			epc        <= pc;       // faulting instruction
			cause[6:2] <= exc_code;
			status[1]  <= 1'b1;     // exl
		end else if (eret) begin
			status[1] <= 1'b0;
		end else if (cp0_we) begin
			case (cp0_reg)
				CP0_STATUS: status <= wdata;
				CP0_CAUSE:  cause  <= wdata;
				CP0_EPC:    epc    <= wdata;
				default:    ; // unimplemented regs ignore writes
			endcase
		end
	end

endmodule

//--- exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
	input  mips_pkg::word_t   pc,
	input  mips_pkg::word_t   inst,
	input  mips_pkg::word_t   op_a,
	input  mips_pkg::word_t   op_b,
	input  mips_pkg::word_t   dmem_rdata,
	input  mips_pkg::word_t   cp0_rdata,
	input  mips_pkg::alu_op_t aluop,
	input  logic              ra_sel,
	input  logic              sign_ext,
	input  logic              srcb_imm,
	input  logic              lui,
	input  logic              jal,
	input  logic              mem_to_reg,
	input  logic              mfc,
	input  logic              alu_signed,
	output mips_pkg::word_t   alu_result,
	output mips_pkg::word_t   wb_data,
	output logic              overflow,
	output logic              branch_eq
);
	import mips_pkg::*;

	word_t imm_ext;
	word_t src_b;
	word_t sum;
	word_t diff;
	logic  add_ov;
	logic  sub_ov;

	////////////////////////////////////////
	// operand b
	assign imm_ext = sign_ext ? {{16{inst[15]}}, inst[15:0]} : {16'b0, inst[15:0]};

	always_comb begin
		if (ra_sel)
			src_b = {27'b0, inst[10:6]}; // shamt for srl
		else if (srcb_imm)
			src_b = imm_ext;
		else
			src_b = op_b;
	end

	////////////////////////////////////////
	// alu
	assign sum  = op_a + src_b;
	assign diff = op_a - src_b;

	// operands agree in sign but result differs
	assign add_ov = (op_a[31] == src_b[31]) && (sum[31] != op_a[31]);
	assign sub_ov = (op_a[31] != src_b[31]) && (diff[31] != op_a[31]);

	always_comb begin
		case (aluop)
			ALU_AND: alu_result = op_a & src_b;
			ALU_OR:  alu_result = op_a | src_b;
			ALU_ADD: alu_result = sum;
			ALU_XOR: alu_result = op_a ^ src_b;
			ALU_NOR: alu_result = ~(op_a | src_b);
			ALU_SRL: alu_result = op_a >> src_b[4:0];
			ALU_SUB: alu_result = diff;
			default: alu_result = {31'b0, $signed(op_a) < $signed(src_b)}; // slt
		endcase
	end

	assign overflow = alu_signed &
		(((aluop == ALU_ADD) & add_ov) | ((aluop == ALU_SUB) & sub_ov));

	assign branch_eq = (op_a == op_b); // rs against rt

	////////////////////////////////////////
	// write-back select
	always_comb begin
		if (jal)
			wb_data = pc + 32'd4; // link address
		else if (lui)
			wb_data = {inst[15:0], 16'b0};
		else if (mfc)
			wb_data = cp0_rdata;
		else if (mem_to_reg)
			wb_data = dmem_rdata;
		else
			wb_data = alu_result;
	end

endmodule

//--- mips_core.sv
`timescale 1ns/10ps

module mips_core #(
	parameter mips_pkg::word_t RESET_PC   = 32'h0000_0000,
	parameter mips_pkg::word_t EXC_VECTOR = 32'h0000_0080
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::word_t     imem_data,
	input  mips_pkg::word_t     dmem_rdata,
	output mips_pkg::word_t     imem_addr,
	output mips_pkg::word_t     dmem_addr,
	output mips_pkg::word_t     dmem_wdata,
	output mips_pkg::word_t     wb_data,
	output logic                dmem_we,
	output logic                wb_we,
	output mips_pkg::reg_addr_t wb_dreg,
	output logic                exc_taken,
	output logic [4:0]          exc_code
);
	import mips_pkg::*;

	logic      ra_sel, beq, bne, j, jr, sign_ext, srcb_imm, lui, jal;
	logic      mem_we, mem_to_reg, dec_wb_we, syscall, unknown;
	logic      alu_signed, eret, cp0_we, mfc, overflow, branch_eq;
	alu_op_t   aluop;
	reg_addr_t cp0_reg;
	reg_addr_t raddr_a;
	word_t     rdata_a;
	word_t     cp0_rdata;
	word_t     epc;

	////////////////////////////////////////
	// decode and register read
	control u_control (
		.inst(imem_data), .ra_sel(ra_sel), .beq(beq), .bne(bne), .j(j), .jr(jr),
		.aluop(aluop), .sign_ext(sign_ext), .srcb_imm(srcb_imm), .lui(lui),
		.jal(jal), .mem_we(mem_we), .mem_to_reg(mem_to_reg), .wb_dreg(wb_dreg),
		.wb_we(dec_wb_we), .syscall(syscall), .unknown(unknown),
		.alu_signed(alu_signed), .eret(eret), .cp0_we(cp0_we),
		.cp0_reg(cp0_reg), .mfc(mfc)
	);

	assign raddr_a = ra_sel ? imem_data[20:16] : imem_data[25:21]; // rt for srl

	// faulting instruction leaves no architectural trace
	assign wb_we   = dec_wb_we & ~exc_taken;
	assign dmem_we = mem_we & ~exc_taken;

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .raddr_a(raddr_a), .raddr_b(imem_data[20:16]),
		.waddr(wb_dreg), .we(wb_we), .wdata(wb_data),
		.rdata_a(rdata_a), .rdata_b(dmem_wdata)
	);

	////////////////////////////////////////
	// execute, cp0 and next pc
	exec_unit u_exec_unit (
		.pc(imem_addr), .inst(imem_data), .op_a(rdata_a), .op_b(dmem_wdata),
		.dmem_rdata(dmem_rdata), .cp0_rdata(cp0_rdata), .aluop(aluop),
		.ra_sel(ra_sel), .sign_ext(sign_ext), .srcb_imm(srcb_imm), .lui(lui),
		.jal(jal), .mem_to_reg(mem_to_reg), .mfc(mfc), .alu_signed(alu_signed),
		.alu_result(dmem_addr), .wb_data(wb_data), .overflow(overflow),
		.branch_eq(branch_eq)
	);

	cp0 u_cp0 (
		.clk(clk), .rst_n(rst_n), .pc(imem_addr), .syscall(syscall),
		.unknown(unknown), .overflow(overflow), .eret(eret), .cp0_we(cp0_we),
		.cp0_reg(cp0_reg), .wdata(dmem_wdata), .rdata(cp0_rdata), .epc(epc),
		.exc_taken(exc_taken), .exc_code(exc_code)
	);

	pc_unit #(
		.RESET_PC(RESET_PC),
		.EXC_VECTOR(EXC_VECTOR)
	) u_pc_unit (
		.clk(clk), .rst_n(rst_n), .inst(imem_data), .epc(epc), .rs_value(rdata_a),
		.beq(beq), .bne(bne), .j(j), .jr(jr), .eret(eret), .branch_eq(branch_eq),
		.exc_taken(exc_taken), .pc(imem_addr)
	);

endmodule

//--- mips_core_properties.sv
`timescale 1ns/10ps

module mips_core_properties (
	input logic                clk,
	input logic                rst_n,
	input mips_pkg::word_t     imem_addr,
	input mips_pkg::word_t     imem_data,
	input logic                wb_we,
	input mips_pkg::reg_addr_t wb_dreg,
	input logic                dmem_we,
	input logic                exc_taken
);

	////////////////////////////////////////
	// fetch and trace properties
	pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		imem_addr[1:0] == 2'b00)
		else $error("imem_addr %h is not word aligned", imem_addr);

	// a faulting instruction writes nothing
	no_write_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
		exc_taken |-> !(wb_we || dmem_we))
		else $error("write enable high together with exc_taken");

	zero_dest_from_field: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_we && wb_dreg == '0) |-> (imem_data[20:16] == '0 || imem_data[15:11] == '0))
		else $error("wb_dreg is zero without a zero destination field");

endmodule

bind mips_core mips_core_properties u_properties (.*);

//--- mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;     // data and address word
	typedef logic [4:0]  reg_addr_t; // gpr or cp0 index
	typedef logic [2:0]  alu_op_t;

	////////////////////////////////////////
	// alu operations
	localparam alu_op_t ALU_AND = 3'b000;
	localparam alu_op_t ALU_OR  = 3'b001;
	localparam alu_op_t ALU_ADD = 3'b010;
	localparam alu_op_t ALU_XOR = 3'b011;
	localparam alu_op_t ALU_NOR = 3'b100;
	localparam alu_op_t ALU_SRL = 3'b101;
	localparam alu_op_t ALU_SUB = 3'b110;
	localparam alu_op_t ALU_SLT = 3'b111; // signed compare

	////////////////////////////////////////
	// primary opcodes, inst[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_COP0  = 6'h10;

	// function field, inst[5:0]
	localparam logic [5:0] FN_ADD     = 6'h20;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUB     = 6'h22;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_SLT     = 6'h2a;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_NOR     = 6'h27;
	localparam logic [5:0] FN_SRL     = 6'h02;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;

	localparam word_t INST_ERET = 32'h4200_0018; // full eret word

	localparam reg_addr_t REG_RA     = 5'd31; // link register
	localparam reg_addr_t CP0_STATUS = 5'd12;
	localparam reg_addr_t CP0_CAUSE  = 5'd13;
	localparam reg_addr_t CP0_EPC    = 5'd14;

	// cause.exccode values
	localparam logic [4:0] EXC_SYS = 5'd8;
	localparam logic [4:0] EXC_RI  = 5'd10;
	localparam logic [4:0] EXC_OV  = 5'd12;

endpackage

//--- pc_unit.sv
`timescale 1ns/10ps

module pc_unit #(
	parameter mips_pkg::word_t RESET_PC   = 32'h0000_0000,
	parameter mips_pkg::word_t EXC_VECTOR = 32'h0000_0080
) (
	input  logic            clk,
	input  logic            rst_n,
	input  mips_pkg::word_t inst,
	input  mips_pkg::word_t epc,
	input  mips_pkg::word_t rs_value,
	input  logic            beq,
	input  logic            bne,
	input  logic            j,
	input  logic            jr,
	input  logic            eret,
	input  logic            branch_eq,
	input  logic            exc_taken,
	output mips_pkg::word_t pc
);
	import mips_pkg::*;

	word_t pc_plus4;
	word_t br_target;
	word_t j_target;
	word_t pc_next;
	logic  br_taken;

	assign pc_plus4  = pc + 32'd4;
	assign br_target = pc_plus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
	assign j_target  = {pc_plus4[31:28], inst[25:0], 2'b00}; // same 256M region
	assign br_taken  = (beq & branch_eq) | (bne & ~branch_eq);

	always_comb begin
		if (exc_taken)
			pc_next = EXC_VECTOR;
		else if (eret)
			pc_next = epc;
		else if (jr)
			pc_next = rs_value;
		else if (j)
			pc_next = j_target;
		else if (br_taken)
			pc_next = br_target;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t raddr_a,
	input  mips_pkg::reg_addr_t raddr_b,
	input  mips_pkg::reg_addr_t waddr,
	input  logic                we,
	input  mips_pkg::word_t     wdata,
	output mips_pkg::word_t     rdata_a,
	output mips_pkg::word_t     rdata_b
);
	import mips_pkg::*;

	word_t regs [32];

	// async read, $zero hard wired
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata; // writes to r0 dropped
		end
	end

endmodule

//--- tb_mips_core.sv
`timescale 1ns/10ps

module tb_mips_core;
	import mips_pkg::*;

	localparam int    MEM_WORDS  = 64;
	localparam int    DMEM_WORDS = 256;
	localparam int    MAX_STEPS  = 200;
	localparam word_t VECTOR     = 32'h0000_0080; // default exception vector
	localparam word_t END_PC     = 32'h0000_00f0; // self loop at word 60

	logic       clk;
	logic       rst_n;
	word_t      imem_data;
	word_t      dmem_rdata;
	word_t      imem_addr;
	word_t      dmem_addr;
	word_t      dmem_wdata;
	word_t      wb_data;
	logic       dmem_we;
	logic       wb_we;
	logic       exc_taken;
	reg_addr_t  wb_dreg;
	logic [4:0] exc_code;

	// program table with the expected exception code per word
	word_t      prog [MEM_WORDS];
	logic [4:0] prog_exc [MEM_WORDS];
	word_t      dmem [DMEM_WORDS];

	// reference model state
	word_t m_regs [32];
	word_t m_mem [DMEM_WORDS];
	word_t m_pc;
	word_t m_epc;
	word_t m_cause;
	word_t m_status;
	word_t cur_pc;

	// expected trace of the current instruction
	logic       e_we;
	logic       e_mwe;
	logic       e_mem;
	logic       e_exc;
	logic [4:0] e_code;
	reg_addr_t  e_dreg;
	word_t      e_data;
	word_t      e_maddr;
	word_t      e_mwdata;

	mips_core uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n && dmem_we)
			dmem[dmem_addr[9:2]] = dmem_wdata;
	end

	function automatic word_t rtype_word(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
		reg_addr_t rd, logic [4:0] sh);
		return {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(logic [5:0] op, int idx);
		return {op, 26'(idx)}; // idx is a word index
	endfunction

	function automatic word_t cop0_word(logic [4:0] sub, reg_addr_t rt, reg_addr_t rd);
		return {OP_COP0, sub, rt, rd, 11'b0};
	endfunction

	function automatic word_t cp0_value(reg_addr_t r);
		case (r)
			CP0_STATUS: return m_status;
			CP0_CAUSE:  return m_cause;
			CP0_EPC:    return m_epc;
			default:    return '0;
		endcase
	endfunction

	task automatic put_constant(int at, reg_addr_t r, word_t v);
		prog[at]     = itype_word(OP_LUI, 5'd0, r, v[31:16]);
		prog[at + 1] = itype_word(OP_ORI, r, r, v[15:0]);
	endtask

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("FAIL %s: got %h, expected %h (pc %h)", name, got, exp, cur_pc);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// program image
	task automatic build_program();
		word_t a;
		word_t b;
		word_t c;
		a = $urandom(32'hca0f) & 32'h3fff_ffff; // first draw sets the seed
		b = $urandom;
		c = $urandom & 32'h3fff_ffff; // a and c keep add and sub in range
		for (int i = 0; i < MEM_WORDS; i++) begin
			prog[i]     = '0;
			prog_exc[i] = '0;
		end
		put_constant(0, 1, a);
		put_constant(2, 2, b);
		put_constant(4, 3, c);
		put_constant(6, 5, 32'h7fff_ffff);
		prog[8]  = rtype_word(FN_ADDU, 1, 2, 6, 0);
		prog[9]  = rtype_word(FN_SUBU, 1, 2, 7, 0);
		prog[10] = rtype_word(FN_SLT, 1, 2, 8, 0);
		prog[11] = rtype_word(FN_AND, 1, 2, 9, 0);
		prog[12] = rtype_word(FN_OR, 1, 2, 10, 0);
		prog[13] = rtype_word(FN_XOR, 1, 2, 11, 0);
		prog[14] = rtype_word(FN_NOR, 1, 2, 12, 0);
		prog[15] = rtype_word(FN_SRL, 0, 1, 13, 7);
		prog[16] = rtype_word(FN_ADD, 1, 3, 14, 0);
		prog[17] = rtype_word(FN_SUB, 1, 3, 15, 0);
		prog[18] = itype_word(OP_ADDI, 1, 16, 16'hfffb);
		prog[19] = itype_word(OP_ANDI, 2, 17, 16'ha5c3);
		prog[20] = itype_word(OP_ORI, 2, 18, 16'h1234);
		prog[21] = itype_word(OP_XORI, 2, 19, 16'hffff);
		prog[22] = itype_word(OP_SLTI, 2, 20, 16'h0010);
		prog[23] = itype_word(OP_LUI, 0, 21, 16'hbeef);
		prog[24] = itype_word(OP_SW, 0, 2, 16'h0100);
		prog[25] = itype_word(OP_LW, 0, 23, 16'h0100);
		prog[26] = itype_word(OP_BEQ, 1, 1, 16'h0001); // taken and skips 27
		prog[27] = rtype_word(FN_ADDU, 1, 1, 24, 0);
		prog[28] = itype_word(OP_BNE, 1, 1, 16'h0005); // falls through
		prog[29] = itype_word(OP_BNE, 1, 2, 16'h0001);
		prog[30] = rtype_word(FN_ADDU, 2, 2, 24, 0);
		prog[31] = jump_word(OP_J, 40);
		// exception handler at the vector returns past the faulting word
		prog[32] = cop0_word(5'd0, 25, CP0_EPC);
		prog[33] = itype_word(OP_ADDI, 25, 25, 16'h0004);
		prog[34] = cop0_word(5'd4, 25, CP0_EPC);
		prog[35] = cop0_word(5'd0, 26, CP0_EPC);
		prog[36] = cop0_word(5'd0, 27, CP0_CAUSE);
		prog[37] = INST_ERET;
		prog[40] = jump_word(OP_JAL, 45);
		prog[41] = itype_word(OP_ORI, 0, 28, 16'h00c0);
		prog[42] = rtype_word(FN_JALR, 28, 0, 31, 0);
		prog[43] = jump_word(OP_J, 60);
		prog[45] = rtype_word(FN_JR, 31, 0, 0, 0);
		prog[48] = rtype_word(FN_ADD, 5, 5, 6, 0);
		prog[49] = rtype_word(FN_SYSCALL, 0, 0, 0, 0);
		prog[50] = 32'hfc00_0000; // opcode 0x3f is not decoded
		prog_exc[48] = EXC_OV;
		prog_exc[49] = EXC_SYS;
		prog_exc[50] = EXC_RI;
		prog[51] = cop0_word(5'd4, 2, CP0_STATUS);
		prog[52] = cop0_word(5'd0, 29, CP0_STATUS);
		prog[53] = cop0_word(5'd0, 30, 5'd0);
		prog[54] = rtype_word(FN_JR, 31, 0, 0, 0);
		prog[60] = jump_word(OP_J, 60);
	endtask

	////////////////////////////////////////
	// reference model for one instruction
	task automatic model_step(input word_t inst);
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rd;
		word_t      a;
		word_t      b;
		word_t      sext;
		word_t      res;
		word_t      next_pc;
		longint     wide;
		op       = inst[31:26];
		fn       = inst[5:0];
		rs       = inst[25:21];
		rd       = inst[15:11];
		a        = m_regs[rs];
		b        = m_regs[inst[20:16]];
		sext     = {{16{inst[15]}}, inst[15:0]};
		res      = '0;
		wide     = 0;
		next_pc  = m_pc + 32'd4;
		e_we     = 1'b0;
		e_mwe    = 1'b0;
		e_mem    = 1'b0;
		e_code   = '0;
		e_dreg   = inst[20:16];
		e_maddr  = a + sext;
		e_mwdata = b;
		if (op == OP_RTYPE && inst != '0) begin
			e_dreg = rd;
			e_we   = 1'b1;
			case (fn)
				FN_ADD, FN_ADDU: begin
					res  = a + b;
					wide = longint'($signed(a)) + longint'($signed(b));
				end
				FN_SUB, FN_SUBU: begin
					res  = a - b;
					wide = longint'($signed(a)) - longint'($signed(b));
				end
				FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_AND: res = a & b;
				FN_OR:  res = a | b;
				FN_XOR: res = a ^ b;
				FN_NOR: res = ~(a | b);
				FN_SRL: res = b >> inst[10:6];
				FN_JR, FN_JALR: begin
					res     = m_pc + 32'd4;
					next_pc = a;
					e_dreg  = REG_RA;
					e_we    = (fn == FN_JALR);
				end
				FN_SYSCALL: e_code = EXC_SYS;
				default:    e_code = EXC_RI;
			endcase
			// result no longer fits in 32 signed bits
			if ((fn == FN_ADD || fn == FN_SUB) && wide != longint'($signed(res)))
				e_code = EXC_OV;
		end else if (op != OP_RTYPE) begin
			case (op)
				OP_ADDI: begin
					res  = a + sext;
					wide = longint'($signed(a)) + longint'($signed(sext));
					e_we = 1'b1;
					if (wide != longint'($signed(res)))
						e_code = EXC_OV;
				end
				OP_SLTI: begin
					res  = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
					e_we = 1'b1;
				end
				OP_ANDI: begin
					res  = a & {16'h0, inst[15:0]};
					e_we = 1'b1;
				end
				OP_ORI: begin
					res  = a | {16'h0, inst[15:0]};
					e_we = 1'b1;
				end
				OP_XORI: begin
					res  = a ^ {16'h0, inst[15:0]};
					e_we = 1'b1;
				end
				OP_LUI: begin
					res  = {inst[15:0], 16'h0};
					e_we = 1'b1;
				end
				OP_LW: begin
					res   = m_mem[e_maddr[9:2]];
					e_we  = 1'b1;
					e_mem = 1'b1;
				end
				OP_SW: begin
					e_mwe = 1'b1;
					e_mem = 1'b1;
				end
				OP_BEQ: if (a == b) next_pc = m_pc + 32'd4 + (sext << 2);
				OP_BNE: if (a != b) next_pc = m_pc + 32'd4 + (sext << 2);
				OP_J, OP_JAL: begin
					next_pc = {next_pc[31:28], inst[25:0], 2'b00};
					res     = m_pc + 32'd4;
					e_dreg  = REG_RA;
					e_we    = (op == OP_JAL);
				end
				OP_COP0: begin
					if (inst == INST_ERET) begin
						next_pc     = m_epc;
						m_status[1] = 1'b0;
					end else if (rs == 5'd0 && inst[10:3] == '0) begin
						res  = cp0_value(rd); // mfc0
						e_we = 1'b1;
					end else if (rs == 5'd4 && inst[10:3] == '0) begin
						case (rd) // mtc0
							CP0_STATUS: m_status = b;
							CP0_CAUSE:  m_cause  = b;
							CP0_EPC:    m_epc    = b;
							default:    ;
						endcase
					end else begin
						e_code = EXC_RI;
					end
				end
				default: e_code = EXC_RI;
			endcase
		end
		e_exc  = (e_code != '0);
		e_data = res;
		if (e_exc) begin
			e_we         = 1'b0;
			e_mwe        = 1'b0;
			m_epc        = m_pc;
			m_cause[6:2] = e_code;
			m_status[1]  = 1'b1;
			next_pc      = VECTOR;
		end else begin
			if (e_we && e_dreg != '0)
				m_regs[e_dreg] = res;
			if (e_mwe)
				m_mem[e_maddr[9:2]] = b;
		end
		m_pc = next_pc;
	endtask

	////////////////////////////////////////
	// main sequence
	initial begin
		int steps;
		rst_n      = 1'b0;
		imem_data  = '0; // nop during reset
		dmem_rdata = '0;
		build_program();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i]  = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
			m_mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
		end
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		m_pc     = 32'h0;
		m_epc    = '0;
		m_cause  = '0;
		m_status = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		steps = 0;
		while (m_pc != END_PC) begin
			assert (steps < MAX_STEPS) else begin
				$display("program did not reach its end loop within %0d steps", MAX_STEPS);
				abort_run();
			end
			cur_pc = m_pc;
			compare_word("imem_addr", imem_addr, m_pc);
			model_step(prog[m_pc[7:2]]);
			imem_data  = prog[imem_addr[7:2]];
			dmem_rdata = dmem[e_maddr[9:2]];
			#1; // let the combinational path settle
			compare_word("exc_taken", exc_taken, e_exc);
			compare_word("exc_code", exc_taken ? exc_code : 5'd0, prog_exc[cur_pc[7:2]]);
			compare_word("wb_we", wb_we, e_we);
			compare_word("dmem_we", dmem_we, e_mwe);
			if (e_we) begin
				compare_word("wb_dreg", wb_dreg, e_dreg);
				compare_word("wb_data", wb_data, e_data);
			end
			if (e_mem)
				compare_word("dmem_addr", dmem_addr, e_maddr);
			if (e_mwe)
				compare_word("dmem_wdata", dmem_wdata, e_mwdata);
			steps++;
			@(negedge clk);
		end
		cur_pc = m_pc;
		compare_word("imem_addr", imem_addr, END_PC);
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- vlog.f
mips_pkg.sv
control.sv
reg_file.sv
exec_unit.sv
cp0.sv
pc_unit.sv
mips_core.sv
mips_core_properties.sv
tb_mips_core.sv
